/* list.f */
+incdir+verification
rtl/bmu_pkg.sv
rtl/bmu_issue.sv
rtl/bmu_count_unit.sv
rtl/bmu_execute.sv
rtl/bmu_result_buffer.sv
rtl/bmu_top.sv
verification/tb_bmu.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the bit-manipulation unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
{ verilator --binary --timing --assert -f list.f --top-module tb_bmu \
    && ./obj_dir/Vtb_bmu; } > sim.log 2>&1 \
    || echo "TESTBENCH FAILED" >> sim.log
cat sim.log
grep -q "TESTBENCH FAILED" sim.log && exit 1 || exit 0

/* verification/bmu_ref_model.svh */
// ------------------------------------------------------------
// Bit-manipulation unit reference model
// Expected result of one request, taken from the B extension
// instruction definitions
// ------------------------------------------------------------

`ifndef BMU_REF_MODEL_SVH
`define BMU_REF_MODEL_SVH

function automatic bmu_pkg::bmu_word_t ref_result(input bmu_pkg::bmu_req_t req);
    bmu_pkg::bmu_word_t a;
    bmu_pkg::bmu_word_t b;
    bmu_pkg::bmu_word_t res;
    logic [63:0]        dbl;
    logic [4:0]         sh;
    int                 cnt;
    a   = req.a;
    b   = req.b;
    sh  = b[4:0];
    res = '0;
    cnt = 0;
    case (req.op.group)
        bmu_pkg::GRP_SHADD: begin
            case (req.op.subop.shadd)
                bmu_pkg::SH1ADD: res = b + (a << 1);
                bmu_pkg::SH2ADD: res = b + (a << 2);
                bmu_pkg::SH3ADD: res = b + (a << 3);
                default:         ;
            endcase
        end
        bmu_pkg::GRP_LOGIC: begin
            case (req.op.subop.logic_op)
                bmu_pkg::ANDN: res = a & ~b;
                bmu_pkg::ORN:  res = a | ~b;
                bmu_pkg::XNOR: res = ~(a ^ b);
                default:       ;
            endcase
        end
        bmu_pkg::GRP_BITOP: begin
            case (req.op.subop.bitop)
                bmu_pkg::BCLR: res = a & ~(32'h1 << sh);
                bmu_pkg::BEXT: res = {31'h0, a[sh]};
                bmu_pkg::BINV: res = a ^ (32'h1 << sh);
                bmu_pkg::BSET: res = a | (32'h1 << sh);
                default:       ;
            endcase
        end
        bmu_pkg::GRP_COUNT: begin
            // Scan from the top for CLZ, from the bottom for CTZ
            case (req.op.subop.count)
                bmu_pkg::CLZ:  while (cnt < 32 && !a[5'(31 - cnt)]) cnt++;
                bmu_pkg::CTZ:  while (cnt < 32 && !a[5'(cnt)]) cnt++;
                bmu_pkg::CPOP: cnt = $countones(a);
                default:       ;
            endcase
            res = bmu_pkg::bmu_word_t'(cnt);
        end
        bmu_pkg::GRP_COMPARE: begin
            case (req.op.subop.compare)
                bmu_pkg::MIN:  res = ($signed(a) < $signed(b)) ? a : b;
                bmu_pkg::MINU: res = (a < b) ? a : b;
                bmu_pkg::MAX:  res = ($signed(a) > $signed(b)) ? a : b;
                bmu_pkg::MAXU: res = (a > b) ? a : b;
                default:       ;
            endcase
        end
        bmu_pkg::GRP_ROTATE: begin
            // Doubled word, the rotated value sits in one half
            if (req.op.subop.rotate == bmu_pkg::ROL) begin
                dbl = {a, a} << sh;
                res = dbl[63:32];
            end else begin
                dbl = {a, a} >> sh;
                res = dbl[31:0];
            end
        end
        bmu_pkg::GRP_BYTEOP: begin
            if (req.op.subop.byteop == bmu_pkg::REV8) begin
                res = {a[7:0], a[15:8], a[23:16], a[31:24]};
            end else begin
                res = {{8{|a[31:24]}}, {8{|a[23:16]}}, {8{|a[15:8]}}, {8{|a[7:0]}}};
            end
        end
        default: begin
            case (req.op.subop.extend)
                bmu_pkg::SEXTB: res = {{24{a[7]}}, a[7:0]};
                bmu_pkg::SEXTH: res = {{16{a[15]}}, a[15:0]};
                bmu_pkg::ZEXTH: res = {16'h0, a[15:0]};
                default:        ;
            endcase
        end
    endcase
    return res;
endfunction

`endif

/* verification/tb_bmu.sv */
// ------------------------------------------------------------
// Bit-manipulation unit testbench
// Back-pressure check, directed table and a random stream,
// all compared in order against the reference model
// ------------------------------------------------------------

`timescale 1ns/1ps

module tb_bmu;

    `include "bmu_ref_model.svh"

    // Table entry holding a request and its expected result
    typedef struct packed {
        bmu_pkg::bmu_req_t  req;
        bmu_pkg::bmu_word_t expected;
    } vec_t;

    // Consumer behavior towards credit_i
    typedef enum {GRANT_NONE, GRANT_ALWAYS, GRANT_RANDOM} grant_e;

    logic               clk;
    logic               rst_n;
    logic               req_valid;
    bmu_pkg::bmu_req_t  req;
    logic               credit_up;
    logic               result_valid;
    bmu_pkg::bmu_word_t result;
    logic               credit_dn;

    vec_t               vec_table [$];
    // Results still owed by the DUT with the oldest first
    bmu_pkg::bmu_word_t exp_q [$];
    grant_e             grant_mode;
    logic [31:0]        lfsr_state;
    int                 sent;
    int                 returned;
    int                 results;
    logic               out_seen;
    // Legal sub-operations per group
    int                 n_sub [8];

    bmu_top u_dut (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .req_valid_i    (req_valid),
        .req_i          (req),
        .credit_o       (credit_up),
        .result_valid_o (result_valid),
        .result_o       (result),
        .credit_i       (credit_dn)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "Run stopped at first error");
    endtask

    // Galois LFSR stepped once per bit taken
    function automatic logic lfsr_bit();
        logic out_bit;
        out_bit    = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out_bit) begin
            lfsr_state = lfsr_state ^ 32'h80200003;
        end
        return out_bit;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    // Producer side credits
    function automatic int credits_held();
        return bmu_pkg::BUF_DEPTH - sent + returned;
    endfunction

    // One cycle that checks DUT outputs and then drives the next inputs
    task automatic step();
        bmu_pkg::bmu_word_t exp_val;
        @(negedge clk);
        out_seen = result_valid | credit_up;
        if (credit_up) begin
            returned++;
        end
        if (result_valid) begin
            assert (exp_q.size() > 0)
                else fail_run("Result arrived with no request outstanding");
            exp_val = exp_q.pop_front();
            assert (result === exp_val)
                else fail_run($sformatf("** Error: result_o = 0x%08h, expected 0x%08h",
                                        result, exp_val));
            results++;
        end
        assert (credits_held() >= 0 && credits_held() <= bmu_pkg::BUF_DEPTH)
            else fail_run("Upstream credit count left its legal range");
        case (grant_mode)
            GRANT_ALWAYS: credit_dn = 1'b1;
            GRANT_RANDOM: credit_dn = (rand_bits(1) != 32'h0);
            default:      credit_dn = 1'b0;
        endcase
        req_valid = 1'b0;
    endtask

    task automatic send_req(input bmu_pkg::bmu_req_t r, input bmu_pkg::bmu_word_t exp_val);
        int waited;
        waited = 0;
        step();
        // Hold back until a credit is free
        while (credits_held() == 0) begin
            assert (waited < 200) else fail_run("Timeout waiting for an upstream credit");
            step();
            waited++;
        end
        req       = r;
        req_valid = 1'b1;
        exp_q.push_back(exp_val);
        sent++;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            assert (waited < 500) else fail_run("Timeout waiting for results to drain");
            step();
            waited++;
        end
    endtask

    task automatic add_vec(input bmu_pkg::bmu_group_e grp, input logic [2:0] sub,
                           input bmu_pkg::bmu_word_t a, input bmu_pkg::bmu_word_t b,
                           input bmu_pkg::bmu_word_t exp_val);
        vec_t v;
        v.req.op   = {grp, sub};
        v.req.a    = a;
        v.req.b    = b;
        v.expected = exp_val;
        // Hand value and reference model must agree
        assert (ref_result(v.req) === exp_val)
            else fail_run($sformatf("** Error: ref_result = 0x%08h, table 0x%08h",
                                    ref_result(v.req), exp_val));
        vec_table.push_back(v);
    endtask

    // ------------------------------------------------------------
    // Directed table
    // ------------------------------------------------------------

    task automatic load_table();
        add_vec(bmu_pkg::GRP_SHADD, bmu_pkg::SH1ADD, 32'h00000010, 32'h00000003, 32'h00000023);
        add_vec(bmu_pkg::GRP_SHADD, bmu_pkg::SH2ADD, 32'h00000010, 32'h00000003, 32'h00000043);
        add_vec(bmu_pkg::GRP_SHADD, bmu_pkg::SH3ADD, 32'h00000010, 32'h00000003, 32'h00000083);
        add_vec(bmu_pkg::GRP_LOGIC, bmu_pkg::ANDN, 32'hFF00FF00, 32'h0F0F0F0F, 32'hF000F000);
        add_vec(bmu_pkg::GRP_LOGIC, bmu_pkg::ORN, 32'hFF00FF00, 32'h0F0F0F0F, 32'hFFF0FFF0);
        add_vec(bmu_pkg::GRP_LOGIC, bmu_pkg::XNOR, 32'hFF00FF00, 32'h0F0F0F0F, 32'h0FF00FF0);
        add_vec(bmu_pkg::GRP_BITOP, bmu_pkg::BCLR, 32'hFFFFFFFF, 32'h00000004, 32'hFFFFFFEF);
        // BEXT returns one bit only
        add_vec(bmu_pkg::GRP_BITOP, bmu_pkg::BEXT, 32'hFFFFFFFF, 32'h00000008, 32'h00000001);
        add_vec(bmu_pkg::GRP_BITOP, bmu_pkg::BEXT, 32'hFFFFFEFF, 32'h00000008, 32'h00000000);
        add_vec(bmu_pkg::GRP_BITOP, bmu_pkg::BINV, 32'h80000000, 32'h0000001F, 32'h00000000);
        add_vec(bmu_pkg::GRP_BITOP, bmu_pkg::BSET, 32'h00000000, 32'h00000025, 32'h00000020);
        // Zero word counts as 32
        add_vec(bmu_pkg::GRP_COUNT, bmu_pkg::CLZ, 32'h00000000, 32'h00000000, 32'h00000020);
        add_vec(bmu_pkg::GRP_COUNT, bmu_pkg::CTZ, 32'h00000000, 32'h00000000, 32'h00000020);
        add_vec(bmu_pkg::GRP_COUNT, bmu_pkg::CLZ, 32'h00010000, 32'h00000000, 32'h0000000F);
        add_vec(bmu_pkg::GRP_COUNT, bmu_pkg::CTZ, 32'h00010000, 32'h00000000, 32'h00000010);
        add_vec(bmu_pkg::GRP_COUNT, bmu_pkg::CPOP, 32'hFFFFFFFF, 32'h00000000, 32'h00000020);
        add_vec(bmu_pkg::GRP_COUNT, bmu_pkg::CPOP, 32'h0F0F0001, 32'h00000000, 32'h00000009);
        // Sign bits differ so signed and unsigned picks disagree
        add_vec(bmu_pkg::GRP_COMPARE, bmu_pkg::MIN, 32'h80000000, 32'h00000001, 32'h80000000);
        add_vec(bmu_pkg::GRP_COMPARE, bmu_pkg::MINU, 32'h80000000, 32'h00000001, 32'h00000001);
        add_vec(bmu_pkg::GRP_COMPARE, bmu_pkg::MAX, 32'h80000000, 32'h00000001, 32'h00000001);
        add_vec(bmu_pkg::GRP_COMPARE, bmu_pkg::MAXU, 32'h80000000, 32'h00000001, 32'h80000000);
        add_vec(bmu_pkg::GRP_ROTATE, bmu_pkg::ROL, 32'h80000001, 32'h00000004, 32'h00000018);
        add_vec(bmu_pkg::GRP_ROTATE, bmu_pkg::ROR, 32'h80000001, 32'h00000004, 32'h18000000);
        // Amounts of 0 and of 32 that wraps to 0
        add_vec(bmu_pkg::GRP_ROTATE, bmu_pkg::ROL, 32'h12345678, 32'h00000000, 32'h12345678);
        add_vec(bmu_pkg::GRP_ROTATE, bmu_pkg::ROR, 32'h12345678, 32'h00000020, 32'h12345678);
        add_vec(bmu_pkg::GRP_BYTEOP, bmu_pkg::ORCB, 32'h00100300, 32'h00000000, 32'h00FFFF00);
        add_vec(bmu_pkg::GRP_BYTEOP, bmu_pkg::REV8, 32'h12345678, 32'h00000000, 32'h78563412);
        add_vec(bmu_pkg::GRP_EXTEND, bmu_pkg::SEXTB, 32'h00000080, 32'h00000000, 32'hFFFFFF80);
        add_vec(bmu_pkg::GRP_EXTEND, bmu_pkg::SEXTB, 32'hFFFFFF7F, 32'h00000000, 32'h0000007F);
        add_vec(bmu_pkg::GRP_EXTEND, bmu_pkg::SEXTH, 32'h12348001, 32'h00000000, 32'hFFFF8001);
        add_vec(bmu_pkg::GRP_EXTEND, bmu_pkg::ZEXTH, 32'hFFFF8001, 32'h00000000, 32'h00008001);
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------

    initial begin
        bmu_pkg::bmu_req_t r;
        logic [2:0]        grp_bits;
        lfsr_state = 32'he739cfca;
        n_sub      = '{3, 3, 4, 3, 4, 2, 2, 3};
        sent       = 0;
        returned   = 0;
        results    = 0;
        out_seen   = 1'b0;
        grant_mode = GRANT_NONE;
        rst_n      = 1'b0;
        req_valid  = 1'b0;
        req        = '0;
        credit_dn  = 1'b0;
        load_table();
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Fill every buffer slot with no downstream credits granted
        for (int i = 0; i < bmu_pkg::BUF_DEPTH; i++) begin
            send_req(vec_table[i].req, vec_table[i].expected);
            assert (!out_seen)
                else fail_run("Result or credit released with no downstream credit");
        end
        for (int i = 0; i < 30; i++) begin
            step();
            assert (!out_seen)
                else fail_run("Result or credit released with no downstream credit");
        end
        // Grants release the held results in order
        grant_mode = GRANT_ALWAYS;
        drain();
        for (int i = bmu_pkg::BUF_DEPTH; i < vec_table.size(); i++) begin
            send_req(vec_table[i].req, vec_table[i].expected);
        end
        drain();

        // Random operations, operands and credit gaps
        grant_mode = GRANT_RANDOM;
        for (int n = 0; n < 200; n++) begin
            grp_bits = 3'(rand_bits(3));
            r.op     = {grp_bits, 3'(rand_bits(2) % n_sub[grp_bits])};
            r.a      = rand_bits(32);
            r.b      = rand_bits(32);
            send_req(r, ref_result(r));
        end
        drain();

        assert (returned == results && results == sent)
            else fail_run("Credit pulses, results and requests do not balance");
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

/* rtl/bmu_top.sv */
// ------------------------------------------------------------
// Bit-manipulation unit top level
// Issue, execute and result buffer in a row, with credit
// flow control towards producer and consumer
// ------------------------------------------------------------

`timescale 1ns/1ps

module bmu_top (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               req_valid_i,
    input  bmu_pkg::bmu_req_t  req_i,
    output logic               credit_o,
    output logic               result_valid_o,
    output bmu_pkg::bmu_word_t result_o,
    input  logic               credit_i
);

    // Issue to execute
    logic               iss_valid;
    bmu_pkg::bmu_req_t  iss_req;
    // Execute to result buffer
    logic               exe_valid;
    bmu_pkg::bmu_word_t exe_result;

    bmu_issue u_issue (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .iss_valid_o (iss_valid),
        .iss_req_o   (iss_req)
    );

    bmu_execute u_execute (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .iss_valid_i  (iss_valid),
        .iss_req_i    (iss_req),
        .exe_valid_o  (exe_valid),
        .exe_result_o (exe_result)
    );

    bmu_result_buffer u_result_buffer (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .exe_valid_i    (exe_valid),
        .exe_result_i   (exe_result),
        .credit_i       (credit_i),
        .result_valid_o (result_valid_o),
        .credit_o       (credit_o),
        .result_o       (result_o)
    );

endmodule

/* rtl/bmu_result_buffer.sv */
// ------------------------------------------------------------
// Bit-manipulation unit result buffer
// FIFO of finished results, released one per downstream
// credit; each release hands one credit back upstream
// ------------------------------------------------------------

`timescale 1ns/1ps

module bmu_result_buffer (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               exe_valid_i,
    input  bmu_pkg::bmu_word_t exe_result_i,
    input  logic               credit_i,
    output logic               result_valid_o,
    output logic               credit_o,
    output bmu_pkg::bmu_word_t result_o
);

    localparam int PTR_W = bmu_pkg::BUF_PTR_W;
    localparam int CRD_W = bmu_pkg::CREDIT_W;

    // Result storage
    bmu_pkg::bmu_word_t mem [bmu_pkg::BUF_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    // Fill level from 0 to BUF_DEPTH
    logic [CRD_W-1:0] fill;
    // Grants received from downstream and not yet used
    logic [CRD_W-1:0] ds_credits;
    logic             send;

    // ------------------------------------------------------------
    // Send side
    // ------------------------------------------------------------

    // Head leaves whenever a result and a credit are both held
    assign send           = (fill != '0) && (ds_credits != '0);
    assign result_valid_o = send;
    assign credit_o       = send;
    assign result_o       = mem[rd_ptr];

    // ------------------------------------------------------------
    // FIFO state
    // ------------------------------------------------------------

    // Upstream credits keep writes from ever hitting a full FIFO
    always_ff @(posedge clk_i) begin
        if (exe_valid_i) begin
            mem[wr_ptr] <= exe_result_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (exe_valid_i) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (send) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Write and send in one cycle leave the level unchanged
            if (exe_valid_i && !send) begin
                fill <= fill + 1'b1;
            end else if (!exe_valid_i && send) begin
                fill <= fill - 1'b1;
            end
        end
    end

    // ------------------------------------------------------------
    // Downstream credit counter
    // ------------------------------------------------------------

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ds_credits <= '0;
        end else if (credit_i && !send) begin
            // Holds at the top instead of wrapping to zero
            if (ds_credits != '1) begin
                ds_credits <= ds_credits + 1'b1;
            end
        end else if (!credit_i && send) begin
            ds_credits <= ds_credits - 1'b1;
        end
    end

endmodule

/* rtl/bmu_execute.sv */
// ------------------------------------------------------------
// Bit-manipulation unit execute stage
// Computes every group's result from the issued operands,
// picks the one named by the group field and registers it
// ------------------------------------------------------------

`timescale 1ns/1ps

module bmu_execute (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               iss_valid_i,
    input  bmu_pkg::bmu_req_t  iss_req_i,
    output logic               exe_valid_o,
    output bmu_pkg::bmu_word_t exe_result_o
);

    localparam int XLEN = bmu_pkg::XLEN;

    bmu_pkg::bmu_word_t            op_a;
    bmu_pkg::bmu_word_t            op_b;
    // Shift amount and bit index, B[4:0]
    logic [bmu_pkg::SHAMT_W-1:0]   shamt;
    logic [bmu_pkg::CNT_W-1:0]     lz_count;
    logic [bmu_pkg::CNT_W-1:0]     pop_count;

    bmu_pkg::bmu_word_t bit_mask;
    bmu_pkg::bmu_word_t a_shr;
    logic               lt_signed;
    logic               lt_unsigned;

    bmu_pkg::bmu_word_t shadd_res;
    bmu_pkg::bmu_word_t logic_res;
    bmu_pkg::bmu_word_t bitop_res;
    bmu_pkg::bmu_word_t count_res;
    bmu_pkg::bmu_word_t compare_res;
    bmu_pkg::bmu_word_t rotate_res;
    bmu_pkg::bmu_word_t byteop_res;
    bmu_pkg::bmu_word_t extend_res;
    bmu_pkg::bmu_word_t result_d;

    assign op_a  = iss_req_i.a;
    assign op_b  = iss_req_i.b;
    assign shamt = iss_req_i.b[bmu_pkg::SHAMT_W-1:0];

    // CTZ operand was already reversed at issue
    bmu_count_unit u_count (
        .operand_i   (op_a),
        .lz_count_o  (lz_count),
        .pop_count_o (pop_count)
    );

    // Shared helpers
    assign bit_mask    = bmu_pkg::bmu_word_t'(1) << shamt;
    assign a_shr       = op_a >> shamt;
    assign lt_signed   = $signed(op_a) < $signed(op_b);
    assign lt_unsigned = op_a < op_b;

    // ------------------------------------------------------------
    // Per-group results
    // ------------------------------------------------------------

    // A arrives pre-shifted
    assign shadd_res = op_a + op_b;

    always_comb begin
        case (iss_req_i.op.subop.logic_op)
            bmu_pkg::ANDN: logic_res = op_a & ~op_b;
            bmu_pkg::ORN:  logic_res = op_a | ~op_b;
            bmu_pkg::XNOR: logic_res = ~(op_a ^ op_b);
            default:       logic_res = '0;
        endcase
    end

    always_comb begin
        case (iss_req_i.op.subop.bitop)
            bmu_pkg::BCLR: bitop_res = op_a & ~bit_mask;
            // Single bit, zero extended
            bmu_pkg::BEXT: bitop_res = {{(XLEN-1){1'b0}}, a_shr[0]};
            bmu_pkg::BINV: bitop_res = op_a ^ bit_mask;
            bmu_pkg::BSET: bitop_res = op_a | bit_mask;
            default:       bitop_res = '0;
        endcase
    end

    always_comb begin
        case (iss_req_i.op.subop.count)
            bmu_pkg::CLZ,
            bmu_pkg::CTZ:  count_res = {{(XLEN-bmu_pkg::CNT_W){1'b0}}, lz_count};
            bmu_pkg::CPOP: count_res = {{(XLEN-bmu_pkg::CNT_W){1'b0}}, pop_count};
            default:       count_res = '0;
        endcase
    end

    always_comb begin
        case (iss_req_i.op.subop.compare)
            bmu_pkg::MIN:  compare_res = lt_signed   ? op_a : op_b;
            bmu_pkg::MINU: compare_res = lt_unsigned ? op_a : op_b;
            bmu_pkg::MAX:  compare_res = lt_signed   ? op_b : op_a;
            bmu_pkg::MAXU: compare_res = lt_unsigned ? op_b : op_a;
            default:       compare_res = '0;
        endcase
    end

    // Shift by XLEN gives zero, so a zero amount returns A
    always_comb begin
        if (iss_req_i.op.subop.rotate == bmu_pkg::ROL) begin
            rotate_res = (op_a << shamt) | (op_a >> (XLEN - shamt));
        end else begin
            rotate_res = (op_a >> shamt) | (op_a << (XLEN - shamt));
        end
    end

    always_comb begin
        for (int i = 0; i < XLEN / 8; i++) begin
            if (iss_req_i.op.subop.byteop == bmu_pkg::REV8) begin
                byteop_res[8*(XLEN/8-1-i) +: 8] = op_a[8*i +: 8];
            end else begin
                // OR-combine fills each nonzero byte with ones
                byteop_res[8*i +: 8] = {8{|op_a[8*i +: 8]}};
            end
        end
    end

    always_comb begin
        case (iss_req_i.op.subop.extend)
            bmu_pkg::SEXTB: extend_res = {{(XLEN-8){op_a[7]}}, op_a[7:0]};
            bmu_pkg::SEXTH: extend_res = {{(XLEN-16){op_a[15]}}, op_a[15:0]};
            bmu_pkg::ZEXTH: extend_res = {{(XLEN-16){1'b0}}, op_a[15:0]};
            default:        extend_res = '0;
        endcase
    end

    // ------------------------------------------------------------
    // Final selection and stage register
    // ------------------------------------------------------------

    always_comb begin
        case (iss_req_i.op.group)
            bmu_pkg::GRP_SHADD:   result_d = shadd_res;
            bmu_pkg::GRP_LOGIC:   result_d = logic_res;
            bmu_pkg::GRP_BITOP:   result_d = bitop_res;
            bmu_pkg::GRP_COUNT:   result_d = count_res;
            bmu_pkg::GRP_COMPARE: result_d = compare_res;
            bmu_pkg::GRP_ROTATE:  result_d = rotate_res;
            bmu_pkg::GRP_BYTEOP:  result_d = byteop_res;
            default:              result_d = extend_res;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            exe_valid_o <= 1'b0;
        end else begin
            exe_valid_o <= iss_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (iss_valid_i) begin
            exe_result_o <= result_d;
        end
    end

endmodule

/* rtl/bmu_count_unit.sv */
// ------------------------------------------------------------
// Bit-manipulation unit count logic
// Leading-zero count and population count of one word,
// purely combinational
// ------------------------------------------------------------

`timescale 1ns/1ps

module bmu_count_unit (
    input  bmu_pkg::bmu_word_t         operand_i,
    output logic [bmu_pkg::CNT_W-1:0] lz_count_o,
    output logic [bmu_pkg::CNT_W-1:0] pop_count_o
);

    localparam int N_BYTES = bmu_pkg::XLEN / 8;

    // Per-byte set-bit counts, 0 to 8
    logic [3:0] byte_cnt [N_BYTES];

    // ------------------------------------------------------------
    // Leading zeros
    // ------------------------------------------------------------

    always_comb begin
        // All-zero word counts as full width
        lz_count_o = bmu_pkg::CNT_W'(bmu_pkg::XLEN);
        // Ascending scan, so the highest set bit wins
        for (int i = 0; i < bmu_pkg::XLEN; i++) begin
            if (operand_i[i]) begin
                lz_count_o = bmu_pkg::CNT_W'(bmu_pkg::XLEN - 1 - i);
            end
        end
    end

    // ------------------------------------------------------------
    // Population count
    // ------------------------------------------------------------

    // First level, one small adder per byte
    always_comb begin
        for (int j = 0; j < N_BYTES; j++) begin
            byte_cnt[j] = '0;
            for (int k = 0; k < 8; k++) begin
                byte_cnt[j] = byte_cnt[j] + 4'(operand_i[8*j + k]);
            end
        end
    end

    // Second level sums the byte counts
    always_comb begin
        pop_count_o = '0;
        for (int j = 0; j < N_BYTES; j++) begin
            pop_count_o = pop_count_o + bmu_pkg::CNT_W'(byte_cnt[j]);
        end
    end

endmodule

/* rtl/bmu_issue.sv */
// ------------------------------------------------------------
// Bit-manipulation unit issue stage
// Registers accepted requests and conditions operand A so
// the execute stage needs no shifter for SHxADD and no
// trailing-zero logic for CTZ
// ------------------------------------------------------------

`timescale 1ns/1ps

module bmu_issue (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              req_valid_i,
    input  bmu_pkg::bmu_req_t req_i,
    output logic              iss_valid_o,
    output bmu_pkg::bmu_req_t iss_req_o
);

    // Request with operand A already conditioned
    bmu_pkg::bmu_req_t req_prep;

    always_comb begin
        req_prep = req_i;
        if (req_i.op.group == bmu_pkg::GRP_SHADD) begin
            // Pre-shift so execute only adds
            case (req_i.op.subop.shadd)
                bmu_pkg::SH1ADD: req_prep.a = req_i.a << 1;
                bmu_pkg::SH2ADD: req_prep.a = req_i.a << 2;
                bmu_pkg::SH3ADD: req_prep.a = req_i.a << 3;
                default:         req_prep.a = req_i.a;
            endcase
        end else if (req_i.op.group == bmu_pkg::GRP_COUNT &&
                     req_i.op.subop.count == bmu_pkg::CTZ) begin
            // Trailing zeros become leading zeros after reversal
            for (int i = 0; i < bmu_pkg::XLEN; i++) begin
                req_prep.a[bmu_pkg::XLEN-1-i] = req_i.a[i];
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            iss_valid_o <= 1'b0;
        end else begin
            iss_valid_o <= req_valid_i;
        end
    end

    // Payload only loads on an accepted request
    always_ff @(posedge clk_i) begin
        if (req_valid_i) begin
            iss_req_o <= req_prep;
        end
    end

endmodule

/* rtl/bmu_pkg.sv */
// ------------------------------------------------------------
// Bit-manipulation unit shared definitions
// Widths, buffer depth, operation encodings and the request
// word that travels from the issue stage to the execute stage
// ------------------------------------------------------------

package bmu_pkg;

    // ------------------------------------------------------------
    // Sizes
    // ------------------------------------------------------------

    // Data word width
    localparam int XLEN = 32;
    // Shift and bit index width
    localparam int SHAMT_W = $clog2(XLEN);
    // Count result, wide enough to hold XLEN itself
    localparam int CNT_W = 6;
    // Result buffer entries, also the initial upstream credits
    localparam int BUF_DEPTH = 4;
    localparam int BUF_PTR_W = $clog2(BUF_DEPTH);
    // Credit counter and fill level width
    localparam int CREDIT_W = 3;

    typedef logic [XLEN-1:0] bmu_word_t;

    // ------------------------------------------------------------
    // Operation encodings
    // ------------------------------------------------------------

    // Group selects which union member holds the sub-operation
    typedef enum logic [2:0] {
        GRP_SHADD,
        GRP_LOGIC,
        GRP_BITOP,
        GRP_COUNT,
        GRP_COMPARE,
        GRP_ROTATE,
        GRP_BYTEOP,
        GRP_EXTEND
    } bmu_group_e;

    typedef enum logic [2:0] { SH1ADD, SH2ADD, SH3ADD } bmu_shadd_e;
    typedef enum logic [2:0] { ANDN, ORN, XNOR } bmu_logic_e;
    // Bit index always comes from operand B, immediates included
    typedef enum logic [2:0] { BCLR, BEXT, BINV, BSET } bmu_bitop_e;
    typedef enum logic [2:0] { CLZ, CTZ, CPOP } bmu_count_e;
    typedef enum logic [2:0] { MIN, MINU, MAX, MAXU } bmu_compare_e;
    typedef enum logic [2:0] { ROL, ROR } bmu_rotate_e;
    typedef enum logic [2:0] { ORCB, REV8 } bmu_byteop_e;
    typedef enum logic [2:0] { SEXTB, SEXTH, ZEXTH } bmu_extend_e;

    // Same 3 bits, read through the member named by the group
    typedef union packed {
        bmu_shadd_e   shadd;
        bmu_logic_e   logic_op;
        bmu_bitop_e   bitop;
        bmu_count_e   count;
        bmu_compare_e compare;
        bmu_rotate_e  rotate;
        bmu_byteop_e  byteop;
        bmu_extend_e  extend;
    } bmu_subop_u;

    // Full operation code, 6 bits
    typedef struct packed {
        bmu_group_e group;
        bmu_subop_u subop;
    } bmu_op_t;

    // Request word, 70 bits
    typedef struct packed {
        bmu_op_t   op;
        bmu_word_t a;
        bmu_word_t b;
    } bmu_req_t;

endpackage
